//--- mips_core.f
+incdir+src
src/mips_pkg.sv
src/regfile.sv
src/id_decode.sv
src/ex_alu.sv
src/wb_result.sv
src/mips_core.sv
testbench/tb_clock.sv
testbench/tb_mips_core.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_mips_core
FILELIST  ?= mips_core.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= -j 0

SOURCES := $(wildcard src/*.sv src/*.svh testbench/*.sv)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) --binary --assert --timing $(VFLAGS) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@grep -q '^\*\*\* PASSED \*\*\*$$' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- testbench/tb_mips_core.sv
`timescale 1ns/1ps
`include "mips_defs.svh"

module tb_mips_core;
    import mips_pkg::*;

    localparam int RESET_CYCLES = 4;
    // clocks per test with the drain
    localparam int LEN_IDLE    = 10;
    localparam int LEN_IMM     = 30;
    localparam int LEN_FWD     = 60;
    localparam int LEN_JUMP    = 28;
    localparam int LEN_BRANCH  = 35;
    localparam int LEN_INVALID = 9;
    localparam int TEST_CYCLES = LEN_IDLE + LEN_IMM + LEN_FWD + LEN_JUMP + LEN_BRANCH
                                 + LEN_INVALID;
    localparam int MAX_CYCLES  = 2 * TEST_CYCLES + RESET_CYCLES;

    localparam logic [5:0] IMM_OPS [7] = '{
        `OP_ORI, `OP_ANDI, `OP_XORI, `OP_LUI, `OP_SLTI, `OP_SLTIU, `OP_ADDIU
    };
    localparam logic [5:0] R_FNS [14] = '{
        `FN_OR, `FN_AND, `FN_XOR, `FN_NOR, `FN_SLLV, `FN_SRLV, `FN_SRAV,
        `FN_SLL, `FN_SRL, `FN_SRA, `FN_SLT, `FN_SLTU, `FN_ADDU, `FN_SUBU
    };

    typedef struct packed {
        branch_t    br;
        reg_write_t wr;
        logic       invalid;
    } expect_t;

    logic               clk;
    logic               reset_i;
    logic               inst_valid_i;
    logic [`DATA_W-1:0] inst_i;
    logic [`DATA_W-1:0] pc_i;
    branch_t            branch_o;
    reg_write_t         wb_o;
    logic               invalid_o;

    logic [`DATA_W-1:0] regs [`NUM_REGS]; // reference register model
    expect_t            d1, d2;           // due one and two cycles after issue
    logic [`DATA_W-1:0] pc_next;
    string              test_name;
    int                 test_checks, test_errors;
    int                 total_checks, total_errors, tests_run;
    int                 cycle_cnt = 0;

    tb_clock #(.PERIOD_NS(20.0)) u_clock (.clk_o(clk));

    mips_core uut (
        .clk          (clk),
        .reset_i      (reset_i),
        .inst_valid_i (inst_valid_i),
        .inst_i       (inst_i),
        .pc_i         (pc_i),
        .branch_o     (branch_o),
        .wb_o         (wb_o),
        .invalid_o    (invalid_o)
    );

    function automatic logic [31:0] rtype_word(input logic [5:0] fn, input logic [4:0] rs,
                                               input logic [4:0] rt, input logic [4:0] rd,
                                               input logic [4:0] sh);
        return {`OP_SPECIAL, rs, rt, rd, sh, fn};
    endfunction

    function automatic logic [31:0] itype_word(input logic [5:0] op, input logic [4:0] rs,
                                               input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] jtype_word(input logic [5:0] op, input logic [31:0] idx);
        return {op, idx[25:0]};
    endfunction

    // architectural effect of one word in program order
    task automatic model_exec(input logic [31:0] w, input logic [31:0] pc, output expect_t e);
        logic [5:0]  op;
        logic [5:0]  fn;
        logic [4:0]  rs, rt, rd, sh;
        logic [31:0] a, b, simm, zimm, pc4, btarget;
        op = w[31:26];
        fn = w[5:0];
        rs = w[25:21];
        rt = w[20:16];
        rd = w[15:11];
        sh = w[10:6];
        a = regs[rs];
        b = regs[rt];
        simm = {{16{w[15]}}, w[15:0]};
        zimm = {16'h0, w[15:0]};
        pc4 = pc + 32'd4;
        btarget = pc4 + {simm[29:0], 2'b00};
        e = '0;
        e.wr.we = 1'b1;
        e.wr.addr = rd;
        case (op)
            `OP_SPECIAL: begin
                case (fn)
                    `FN_OR:   e.wr.data = a | b;
                    `FN_AND:  e.wr.data = a & b;
                    `FN_XOR:  e.wr.data = a ^ b;
                    `FN_NOR:  e.wr.data = ~(a | b);
                    `FN_SLLV: e.wr.data = b << a[4:0];
                    `FN_SRLV: e.wr.data = b >> a[4:0];
                    `FN_SRAV: e.wr.data = $signed(b) >>> a[4:0];
                    `FN_SLL:  e.wr.data = b << sh;
                    `FN_SRL:  e.wr.data = b >> sh;
                    `FN_SRA:  e.wr.data = $signed(b) >>> sh;
                    `FN_SLT:  e.wr.data = {31'b0, $signed(a) < $signed(b)};
                    `FN_SLTU: e.wr.data = {31'b0, a < b};
                    `FN_ADDU: e.wr.data = a + b;
                    `FN_SUBU: e.wr.data = a - b;
                    `FN_JR, `FN_JALR: begin
                        e.br.taken = 1'b1;
                        e.br.target = a;
                        e.wr.we = (fn == `FN_JALR);
                        e.wr.data = pc + 32'd8;
                    end
                    default: e.invalid = 1'b1;
                endcase
            end
            `OP_ADDIU: e.wr.data = a + simm;
            `OP_SLTI:  e.wr.data = {31'b0, $signed(a) < $signed(simm)};
            `OP_SLTIU: e.wr.data = {31'b0, a < simm};
            `OP_ANDI:  e.wr.data = a & zimm;
            `OP_ORI:   e.wr.data = a | zimm;
            `OP_XORI:  e.wr.data = a ^ zimm;
            `OP_LUI:   e.wr.data = {w[15:0], 16'h0};
            `OP_BEQ, `OP_BNE, `OP_BLEZ, `OP_BGTZ: begin
                e.wr.we = 1'b0;
                e.br.target = btarget;
                case (op)
                    `OP_BEQ:  e.br.taken = (a == b);
                    `OP_BNE:  e.br.taken = (a != b);
                    `OP_BLEZ: e.br.taken = a[31] || (a == 32'd0);
                    default:  e.br.taken = !a[31] && (a != 32'd0);
                endcase
            end
            `OP_REGIMM: begin
                e.br.target = btarget;
                e.wr.addr = `LINK_REG;
                e.wr.data = pc + 32'd8;
                e.wr.we = (rt == `RT_BLTZAL) || (rt == `RT_BGEZAL); // link even if not taken
                case (rt)
                    `RT_BLTZ, `RT_BLTZAL: e.br.taken = a[31];
                    `RT_BGEZ, `RT_BGEZAL: e.br.taken = !a[31];
                    default:              e.invalid = 1'b1;
                endcase
            end
            `OP_J, `OP_JAL: begin
                e.br.taken = 1'b1;
                e.br.target = {pc4[31:28], w[25:0], 2'b00};
                e.wr.we = (op == `OP_JAL);
                e.wr.addr = `LINK_REG;
                e.wr.data = pc + 32'd8;
            end
            default: e.invalid = 1'b1;
        endcase
        if (op inside {`OP_ADDIU, `OP_SLTI, `OP_SLTIU, `OP_ANDI, `OP_ORI, `OP_XORI, `OP_LUI})
            e.wr.addr = rt;
        if (e.invalid) begin
            e.wr.we = 1'b0;
            e.br.taken = 1'b0;
        end
        if (e.wr.we && (e.wr.addr != 5'd0))
            regs[e.wr.addr] = e.wr.data;
    endtask

    task automatic expect_equal(input string what, input logic [31:0] expv,
                                input logic [31:0] actv);
        test_checks++;
        assert (actv === expv) else begin
            test_errors++;
            $display("Mismatch in %s, %s: expected %h, actual %h", test_name, what, expv, actv);
        end
    endtask

    task automatic compare_outputs();
        expect_equal("branch taken", 32'(d1.br.taken), 32'(branch_o.taken));
        if (d1.br.taken)
            expect_equal("branch target", d1.br.target, branch_o.target);
        expect_equal("write enable", 32'(d2.wr.we), 32'(wb_o.we));
        if (d2.wr.we) begin
            expect_equal("write address", 32'(d2.wr.addr), 32'(wb_o.addr));
            expect_equal("write data", d2.wr.data, wb_o.data);
        end
        expect_equal("invalid pulse", 32'(d2.invalid), 32'(invalid_o));
    endtask

    // drive one word or a bubble and check what is due now
    task automatic step(input logic valid, input logic [31:0] w);
        expect_t cur;
        cur = '0;
        @(posedge clk);
        inst_valid_i <= valid;
        inst_i       <= w;
        pc_i         <= pc_next;
        if (valid) begin
            model_exec(w, pc_next, cur);
            pc_next = pc_next + 32'd4;
        end
        @(negedge clk);
        compare_outputs();
        d2 = d1;
        d1 = cur;
    endtask

    task automatic load_reg(input logic [4:0] r, input logic [31:0] value);
        step(1'b1, itype_word(`OP_LUI, 5'd0, r, value[31:16]));
        step(1'b1, itype_word(`OP_ORI, r, r, value[15:0]));
    endtask

    task automatic start_test(input string name);
        test_name = name;
        test_checks = 0;
        test_errors = 0;
    endtask

    task automatic finish_test();
        step(1'b0, '0); // drain the two younger stages
        step(1'b0, '0);
        tests_run++;
        total_checks += test_checks;
        total_errors += test_errors;
        $display("test %s: %0d checks, %0d errors", test_name, test_checks, test_errors);
    endtask

    task automatic idle_quiet();
        start_test("idle_quiet");
        repeat (8) step(1'b0, '0);
        finish_test();
    endtask

    task automatic imm_ops();
        logic [4:0] rs, rt;
        start_test("imm_ops");
        for (int i = 0; i < 28; i++) begin
            rs = 5'($urandom);
            rt = 5'(1 + $urandom % 31);
            step(1'b1, itype_word(IMM_OPS[i % 7], rs, rt, 16'($urandom)));
        end
        finish_test();
    endtask

    // each op reads the result d ops back through rs or rt in turn
    task automatic forwarding_chain();
        logic [4:0] dst, src, other, sh;
        start_test("forwarding_chain");
        for (int r = 1; r <= 8; r++)
            load_reg(5'(r), $urandom);
        for (int d = 1; d <= 3; d++) begin
            for (int i = 0; i < 14; i++) begin
                dst = 5'(10 + (d * 14 + i) % 16);
                src = 5'(10 + (d * 14 + i - d) % 16);
                other = 5'(1 + i % 8);
                sh = 5'($urandom);
                if ((i % 2 == 0) && !(R_FNS[i] inside {`FN_SLL, `FN_SRL, `FN_SRA}))
                    step(1'b1, rtype_word(R_FNS[i], src, other, dst, sh));
                else
                    step(1'b1, rtype_word(R_FNS[i], other, src, dst, sh)); // constant shifts read rt
            end
        end
        finish_test();
    endtask

    task automatic jumps_and_links();
        logic [4:0] link_rd;
        start_test("jumps_and_links");
        load_reg(5'd6, $urandom & 32'hffff_fffc);
        for (int k = 0; k < 4; k++) begin
            link_rd = 5'(8 + k);
            pc_next = $urandom & 32'hffff_fffc;
            step(1'b1, jtype_word(`OP_J, $urandom));
            step(1'b1, jtype_word(`OP_JAL, $urandom));
            step(1'b1, rtype_word(`FN_ADDU, `LINK_REG, 5'd0, 5'd20, 5'd0)); // ra right behind jal
            step(1'b1, rtype_word(`FN_JR, 5'd20, 5'd0, 5'd0, 5'd0));
            step(1'b1, rtype_word(`FN_JALR, 5'd6, 5'd0, link_rd, 5'd0));
            step(1'b1, rtype_word(`FN_OR, link_rd, 5'd0, 5'd21, 5'd0));
        end
        finish_test();
    endtask

    task automatic branch_conditions();
        logic [4:0]  rs, rt;
        logic [15:0] off;
        logic [31:0] w;
        start_test("branch_conditions");
        load_reg(5'd1, ($urandom & 32'h7fff_ffff) | 32'h1); // positive
        load_reg(5'd2, 32'h0);
        load_reg(5'd3, $urandom | 32'h8000_0000);           // negative
        for (int g = 0; g < 3; g++) begin
            rs = 5'(1 + g);
            rt = (g == 1) ? 5'd1 : rs; // equal, unequal, equal
            for (int b = 0; b < 8; b++) begin
                off = 16'($urandom);
                case (b)
                    0: w = itype_word(`OP_BEQ, rs, rt, off);
                    1: w = itype_word(`OP_BNE, rs, rt, off);
                    2: w = itype_word(`OP_BGTZ, rs, 5'd0, off);
                    3: w = itype_word(`OP_BLEZ, rs, 5'd0, off);
                    4: w = itype_word(`OP_REGIMM, rs, `RT_BGEZ, off);
                    5: w = itype_word(`OP_REGIMM, rs, `RT_BLTZ, off);
                    6: w = itype_word(`OP_REGIMM, rs, `RT_BGEZAL, off);
                    default: w = itype_word(`OP_REGIMM, rs, `RT_BLTZAL, off);
                endcase
                step(1'b1, w);
            end
            step(1'b1, rtype_word(`FN_ADDU, `LINK_REG, 5'd0, 5'd22, 5'd0));
        end
        finish_test();
    endtask

    task automatic invalid_and_r0();
        start_test("invalid_and_r0");
        step(1'b1, itype_word(6'b100011, 5'd1, 5'd5, 16'h0010)); // lw
        step(1'b1, itype_word(6'b101011, 5'd1, 5'd5, 16'h0010)); // sw
        step(1'b1, itype_word(`OP_ADDIU, 5'd1, 5'd0, 16'h1234));
        step(1'b1, rtype_word(`FN_OR, 5'd0, 5'd0, 5'd11, 5'd0));
        step(1'b1, rtype_word(`FN_OR, 5'd0, 5'd0, 5'd12, 5'd0));
        step(1'b1, rtype_word(`FN_OR, 5'd0, 5'd0, 5'd13, 5'd0));
        step(1'b1, rtype_word(`FN_OR, 5'd5, 5'd0, 5'd14, 5'd0)); // $5 untouched by lw
        finish_test();
    endtask

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("timeout: run still going after %0d cycles", MAX_CYCLES);
            $display("*** FAILED ***");
            $finish;
        end
    end

    initial begin
        void'($urandom(32'hd6fa_91d0));
        reset_i      = 1'b1;
        inst_valid_i = 1'b0;
        inst_i       = '0;
        pc_i         = '0;
        pc_next      = 32'h0040_0000;
        d1           = '0;
        d2           = '0;
        tests_run    = 0;
        total_checks = 0;
        total_errors = 0;
        for (int k = 0; k < `NUM_REGS; k++)
            regs[k] = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        reset_i <= 1'b0;

        idle_quiet();
        imm_ops();
        forwarding_chain();
        jumps_and_links();
        branch_conditions();
        invalid_and_r0();

        $display("tests: %0d, checks: %0d, errors: %0d", tests_run, total_checks, total_errors);
        if (total_errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

//--- testbench/tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
    parameter real PERIOD_NS = 20.0
) (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2.0) clk_o = ~clk_o;
    end

endmodule

//--- src/mips_core.sv
`timescale 1ns/1ps
`include "mips_defs.svh"

module mips_core (
    input  logic                 clk,
    input  logic                 reset_i,
    input  logic                 inst_valid_i,
    input  logic [`DATA_W-1:0]   inst_i,
    input  logic [`DATA_W-1:0]   pc_i,
    output mips_pkg::branch_t    branch_o,
    output mips_pkg::reg_write_t wb_o,
    output logic                 invalid_o
);
    import mips_pkg::*;

    logic [`REG_ADDR_W-1:0] raddr1, raddr2;
    logic [`DATA_W-1:0]     rdata1, rdata2;
    reg_write_t             ex_fwd, wb_fwd;
    id_ex_t                 id_ex;
    ex_wb_t                 ex_wb;

    regfile u_regfile (
        .clk      (clk),
        .reset_i  (reset_i),
        .raddr1_i (raddr1),
        .raddr2_i (raddr2),
        .rdata1_o (rdata1),
        .rdata2_o (rdata2),
        .wr_i     (wb_fwd)
    );

    id_decode u_id_decode (
        .clk          (clk),
        .reset_i      (reset_i),
        .inst_valid_i (inst_valid_i),
        .inst_i       (inst_i),
        .pc_i         (pc_i),
        .rdata1_i     (rdata1),
        .rdata2_i     (rdata2),
        .ex_fwd_i     (ex_fwd),
        .wb_fwd_i     (wb_fwd),
        .raddr1_o     (raddr1),
        .raddr2_o     (raddr2),
        .id_ex_o      (id_ex),
        .branch_o     (branch_o)
    );

    ex_alu u_ex_alu (
        .clk      (clk),
        .reset_i  (reset_i),
        .id_ex_i  (id_ex),
        .ex_fwd_o (ex_fwd),
        .ex_wb_o  (ex_wb)
    );

    wb_result u_wb_result (
        .clk       (clk),
        .reset_i   (reset_i),
        .ex_wb_i   (ex_wb),
        .wb_o      (wb_fwd),
        .invalid_o (invalid_o)
    );

    assign wb_o = wb_fwd; // write port is also the core output

endmodule

//--- src/wb_result.sv
`timescale 1ns/1ps
`include "mips_defs.svh"

module wb_result (
    input  logic                 clk,
    input  logic                 reset_i,
    input  mips_pkg::ex_wb_t     ex_wb_i,
    output mips_pkg::reg_write_t wb_o,
    output logic                 invalid_o
);
    import mips_pkg::*;

    ex_wb_t wb_q;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            wb_q.res_sel <= RES_NONE;
            wb_q.wreg    <= 1'b0;
            wb_q.invalid <= 1'b0;
        end else begin
            wb_q.res_sel <= ex_wb_i.res_sel;
            wb_q.wreg    <= ex_wb_i.wreg;
            wb_q.invalid <= ex_wb_i.invalid;
        end
        wb_q.result    <= ex_wb_i.result;
        wb_q.link_addr <= ex_wb_i.link_addr;
        wb_q.wd        <= ex_wb_i.wd;
    end

    // regfile takes this at the end of the cycle
    assign wb_o.we   = wb_q.wreg && !wb_q.invalid;
    assign wb_o.addr = wb_q.wd;
    assign wb_o.data = (wb_q.res_sel == RES_LINK) ? wb_q.link_addr : wb_q.result;

    assign invalid_o = wb_q.invalid;

endmodule

//--- src/ex_alu.sv
`timescale 1ns/1ps
`include "mips_defs.svh"

module ex_alu (
    input  logic                 clk,
    input  logic                 reset_i,
    input  mips_pkg::id_ex_t     id_ex_i,
    output mips_pkg::reg_write_t ex_fwd_o,
    output mips_pkg::ex_wb_t     ex_wb_o
);
    import mips_pkg::*;

    id_ex_t             ex_q;
    logic [4:0]         shamt;
    logic [`DATA_W-1:0] alu_res;

    // execute stage register
    always_ff @(posedge clk) begin
        if (reset_i) begin
            ex_q.alu_op  <= ALU_NOP;
            ex_q.res_sel <= RES_NONE;
            ex_q.wreg    <= 1'b0;
            ex_q.invalid <= 1'b0;
        end else begin
            ex_q.alu_op  <= id_ex_i.alu_op;
            ex_q.res_sel <= id_ex_i.res_sel;
            ex_q.wreg    <= id_ex_i.wreg;
            ex_q.invalid <= id_ex_i.invalid;
        end
        ex_q.op1       <= id_ex_i.op1;
        ex_q.op2       <= id_ex_i.op2;
        ex_q.link_addr <= id_ex_i.link_addr;
        ex_q.wd        <= id_ex_i.wd;
    end

    assign shamt = ex_q.op1[4:0];

    always_comb begin
        case (ex_q.alu_op)
            ALU_OR:   alu_res = ex_q.op1 | ex_q.op2;
            ALU_AND:  alu_res = ex_q.op1 & ex_q.op2;
            ALU_XOR:  alu_res = ex_q.op1 ^ ex_q.op2;
            ALU_NOR:  alu_res = ~(ex_q.op1 | ex_q.op2);
            ALU_SLL:  alu_res = ex_q.op2 << shamt;
            ALU_SRL:  alu_res = ex_q.op2 >> shamt;
            ALU_SRA:  alu_res = $signed(ex_q.op2) >>> shamt;
            ALU_SLT:  alu_res = `DATA_W'($signed(ex_q.op1) < $signed(ex_q.op2));
            ALU_SLTU: alu_res = `DATA_W'(ex_q.op1 < ex_q.op2);
            ALU_ADDU: alu_res = ex_q.op1 + ex_q.op2;
            ALU_SUBU: alu_res = ex_q.op1 - ex_q.op2;
            default:  alu_res = '0;
        endcase
    end

    // value seen by the decode stage one instruction behind
    assign ex_fwd_o.we   = ex_q.wreg;
    assign ex_fwd_o.addr = ex_q.wd;
    assign ex_fwd_o.data = (ex_q.res_sel == RES_LINK) ? ex_q.link_addr : alu_res;

    assign ex_wb_o.res_sel   = ex_q.res_sel;
    assign ex_wb_o.result    = alu_res;
    assign ex_wb_o.link_addr = ex_q.link_addr;
    assign ex_wb_o.wd        = ex_q.wd;
    assign ex_wb_o.wreg      = ex_q.wreg;
    assign ex_wb_o.invalid   = ex_q.invalid;

endmodule

//--- src/id_decode.sv
`timescale 1ns/1ps
`include "mips_defs.svh"

module id_decode (
    input  logic                   clk,
    input  logic                   reset_i,
    input  logic                   inst_valid_i,
    input  mips_pkg::inst_u        inst_i,
    input  logic [`DATA_W-1:0]     pc_i,
    input  logic [`DATA_W-1:0]     rdata1_i,
    input  logic [`DATA_W-1:0]     rdata2_i,
    input  mips_pkg::reg_write_t   ex_fwd_i,
    input  mips_pkg::reg_write_t   wb_fwd_i,
    output logic [`REG_ADDR_W-1:0] raddr1_o,
    output logic [`REG_ADDR_W-1:0] raddr2_o,
    output mips_pkg::id_ex_t       id_ex_o,
    output mips_pkg::branch_t      branch_o
);
    import mips_pkg::*;

    alu_op_e                alu_op;
    res_sel_e               res_sel;
    logic                   re1, re2;
    logic                   wreg, valid_inst;
    logic                   jump, jump_reg, cond_br, br_cond;
    logic [`REG_ADDR_W-1:0] wd;
    logic [`DATA_W-1:0]     imm, op1, op2;
    logic [`DATA_W-1:0]     pc_plus4, pc_plus8, br_target, jmp_target;

    // execute stage is younger, so it wins over wb
    function automatic logic [`DATA_W-1:0] fwd_sel(
        input logic [`REG_ADDR_W-1:0] addr,
        input logic [`DATA_W-1:0]     rdata,
        input reg_write_t             ex_src,
        input reg_write_t             wb_src
    );
        if (ex_src.we && (ex_src.addr != '0) && (ex_src.addr == addr)) begin
            return ex_src.data;
        end else if (wb_src.we && (wb_src.addr != '0) && (wb_src.addr == addr)) begin
            return wb_src.data;
        end
        return rdata;
    endfunction

    assign raddr1_o   = inst_i.r.rs;
    assign raddr2_o   = inst_i.r.rt;
    assign pc_plus4   = pc_i + `DATA_W'(4);
    assign pc_plus8   = pc_i + `DATA_W'(8);
    assign br_target  = pc_plus4 + {{14{inst_i.i.imm[15]}}, inst_i.i.imm, 2'b00};
    assign jmp_target = {pc_plus4[31:28], inst_i.j.index, 2'b00};

    always_comb begin
        alu_op     = ALU_NOP;
        res_sel    = RES_NONE;
        re1        = 1'b0;
        re2        = 1'b0;
        imm        = '0;
        wd         = inst_i.r.rd;
        wreg       = 1'b0;
        valid_inst = 1'b0;
        jump       = 1'b0;
        jump_reg   = 1'b0;
        cond_br    = 1'b0;
        case (inst_i.r.opcode)
            `OP_SPECIAL: begin
                valid_inst = 1'b1;
                re1        = 1'b1;
                re2        = 1'b1;
                wreg       = 1'b1;
                res_sel    = RES_ALU;
                case (inst_i.r.funct)
                    `FN_OR:            alu_op = ALU_OR;
                    `FN_AND:           alu_op = ALU_AND;
                    `FN_XOR:           alu_op = ALU_XOR;
                    `FN_NOR:           alu_op = ALU_NOR;
                    `FN_SLL, `FN_SLLV: alu_op = ALU_SLL;
                    `FN_SRL, `FN_SRLV: alu_op = ALU_SRL;
                    `FN_SRA, `FN_SRAV: alu_op = ALU_SRA;
                    `FN_SLT:           alu_op = ALU_SLT;
                    `FN_SLTU:          alu_op = ALU_SLTU;
                    `FN_ADDU:          alu_op = ALU_ADDU;
                    `FN_SUBU:          alu_op = ALU_SUBU;
                    `FN_JR, `FN_JALR: begin
                        re2      = 1'b0;
                        jump_reg = 1'b1;
                        wreg     = (inst_i.r.funct == `FN_JALR);
                        res_sel  = (inst_i.r.funct == `FN_JALR) ? RES_LINK : RES_NONE;
                    end
                    default: begin
                        valid_inst = 1'b0;
                        re1        = 1'b0;
                        re2        = 1'b0;
                        wreg       = 1'b0;
                        res_sel    = RES_NONE;
                    end
                endcase
                if (inst_i.r.funct inside {`FN_SLL, `FN_SRL, `FN_SRA}) begin
                    re1 = 1'b0; // amount comes from shamt
                    imm = `DATA_W'(inst_i.r.shamt);
                end
            end
            `OP_REGIMM: begin
                if (inst_i.i.rt inside {`RT_BLTZ, `RT_BGEZ, `RT_BLTZAL, `RT_BGEZAL}) begin
                    valid_inst = 1'b1;
                    re1        = 1'b1;
                    cond_br    = 1'b1;
                end
                if (inst_i.i.rt inside {`RT_BLTZAL, `RT_BGEZAL}) begin
                    wreg    = 1'b1; // links taken or not
                    wd      = `LINK_REG;
                    res_sel = RES_LINK;
                end
            end
            `OP_J, `OP_JAL: begin
                valid_inst = 1'b1;
                jump       = 1'b1;
                if (inst_i.j.opcode == `OP_JAL) begin
                    wreg    = 1'b1;
                    wd      = `LINK_REG;
                    res_sel = RES_LINK;
                end
            end
            `OP_BEQ, `OP_BNE, `OP_BLEZ, `OP_BGTZ: begin
                valid_inst = 1'b1;
                re1        = 1'b1;
                re2        = inst_i.i.opcode inside {`OP_BEQ, `OP_BNE};
                cond_br    = 1'b1;
            end
            `OP_ORI, `OP_ANDI, `OP_XORI, `OP_LUI, `OP_ADDIU, `OP_SLTI, `OP_SLTIU: begin
                valid_inst = 1'b1;
                re1        = (inst_i.i.opcode != `OP_LUI); // lui is imm | imm
                wreg       = 1'b1;
                wd         = inst_i.i.rt;
                res_sel    = RES_ALU;
                case (inst_i.i.opcode)
                    `OP_ADDIU: alu_op = ALU_ADDU;
                    `OP_SLTI:  alu_op = ALU_SLT;
                    `OP_SLTIU: alu_op = ALU_SLTU;
                    `OP_ANDI:  alu_op = ALU_AND;
                    `OP_XORI:  alu_op = ALU_XOR;
                    default:   alu_op = ALU_OR;
                endcase
                if (inst_i.i.opcode == `OP_LUI) begin
                    imm = {inst_i.i.imm, 16'h0};
                end else if (inst_i.i.opcode inside {`OP_ORI, `OP_ANDI, `OP_XORI}) begin
                    imm = {16'h0, inst_i.i.imm};
                end else begin
                    imm = {{16{inst_i.i.imm[15]}}, inst_i.i.imm};
                end
            end
            default: ;
        endcase
    end

    assign op1 = re1 ? fwd_sel(inst_i.r.rs, rdata1_i, ex_fwd_i, wb_fwd_i) : imm;
    assign op2 = re2 ? fwd_sel(inst_i.r.rt, rdata2_i, ex_fwd_i, wb_fwd_i) : imm;

    always_comb begin
        case (inst_i.i.opcode)
            `OP_BEQ:    br_cond = (op1 == op2);
            `OP_BNE:    br_cond = (op1 != op2);
            `OP_BLEZ:   br_cond = op1[`DATA_W-1] || (op1 == '0);
            `OP_BGTZ:   br_cond = !op1[`DATA_W-1] && (op1 != '0);
            `OP_REGIMM: br_cond = inst_i.i.rt[0] ? !op1[`DATA_W-1] : op1[`DATA_W-1];
            default:    br_cond = 1'b0;
        endcase
    end

    always_comb begin
        id_ex_o        = '0;
        id_ex_o.alu_op = ALU_NOP; // bubble without a strobe
        if (inst_valid_i) begin
            id_ex_o.alu_op    = alu_op;
            id_ex_o.res_sel   = res_sel;
            id_ex_o.op1       = op1;
            id_ex_o.op2       = op2;
            id_ex_o.link_addr = pc_plus8;
            id_ex_o.wd        = wd;
            id_ex_o.wreg      = wreg;
            id_ex_o.invalid   = !valid_inst;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            branch_o.taken <= 1'b0;
        end else begin
            branch_o.taken <= inst_valid_i && (jump || jump_reg || (cond_br && br_cond));
        end
        branch_o.target <= jump ? jmp_target : (jump_reg ? op1 : br_target);
    end

endmodule

//--- src/regfile.sv
`timescale 1ns/1ps
`include "mips_defs.svh"

module regfile (
    input  logic                   clk,
    input  logic                   reset_i,
    input  logic [`REG_ADDR_W-1:0] raddr1_i,
    input  logic [`REG_ADDR_W-1:0] raddr2_i,
    output logic [`DATA_W-1:0]     rdata1_o,
    output logic [`DATA_W-1:0]     rdata2_o,
    input  mips_pkg::reg_write_t   wr_i
);

    logic [`DATA_W-1:0] regs [`NUM_REGS];

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int k = 0; k < `NUM_REGS; k++) begin
                regs[k] <= '0;
            end
        end else if (wr_i.we && (wr_i.addr != '0)) begin
            regs[wr_i.addr] <= wr_i.data; // $0 stays zero
        end
    end

    // a reader three back sees the value wb wrote
    assign rdata1_o = (raddr1_i == '0) ? '0 : regs[raddr1_i];
    assign rdata2_o = (raddr2_i == '0) ? '0 : regs[raddr2_i];

endmodule

//--- src/mips_pkg.sv
`include "mips_defs.svh"

package mips_pkg;

    typedef enum logic [3:0] {
        ALU_OR, ALU_AND, ALU_XOR, ALU_NOR,
        ALU_SLL, ALU_SRL, ALU_SRA,
        ALU_SLT, ALU_SLTU, ALU_ADDU, ALU_SUBU,
        ALU_NOP
    } alu_op_e;

    typedef enum logic [1:0] {
        RES_NONE, // bubble, branch or invalid
        RES_ALU,
        RES_LINK
    } res_sel_e;

    typedef struct packed {
        logic [5:0]             opcode;
        logic [`REG_ADDR_W-1:0] rs;
        logic [`REG_ADDR_W-1:0] rt;
        logic [`REG_ADDR_W-1:0] rd;
        logic [4:0]             shamt;
        logic [5:0]             funct;
    } r_fields_t;

    typedef struct packed {
        logic [5:0]             opcode;
        logic [`REG_ADDR_W-1:0] rs;
        logic [`REG_ADDR_W-1:0] rt;
        logic [15:0]            imm;
    } i_fields_t;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [25:0] index;
    } j_fields_t;

    // one instruction word, viewed by format
    typedef union packed {
        r_fields_t r;
        i_fields_t i;
        j_fields_t j;
    } inst_u;

    typedef struct packed {
        logic                   we;
        logic [`REG_ADDR_W-1:0] addr;
        logic [`DATA_W-1:0]     data;
    } reg_write_t;

    typedef struct packed {
        logic               taken;
        logic [`DATA_W-1:0] target;
    } branch_t;

    typedef struct packed {
        alu_op_e                alu_op;
        res_sel_e               res_sel;
        logic [`DATA_W-1:0]     op1;
        logic [`DATA_W-1:0]     op2;
        logic [`DATA_W-1:0]     link_addr;
        logic [`REG_ADDR_W-1:0] wd;
        logic                   wreg;
        logic                   invalid;
    } id_ex_t;

    typedef struct packed {
        res_sel_e               res_sel;
        logic [`DATA_W-1:0]     result;
        logic [`DATA_W-1:0]     link_addr;
        logic [`REG_ADDR_W-1:0] wd;
        logic                   wreg;
        logic                   invalid;
    } ex_wb_t;

endpackage

//--- src/mips_defs.svh
`ifndef MIPS_DEFS_SVH
`define MIPS_DEFS_SVH

`define DATA_W      32
`define REG_ADDR_W  5
`define NUM_REGS    32
`define LINK_REG    5'd31  // ra

// primary opcodes
`define OP_SPECIAL  6'b000000
`define OP_REGIMM   6'b000001
`define OP_J        6'b000010
`define OP_JAL      6'b000011
`define OP_BEQ      6'b000100
`define OP_BNE      6'b000101
`define OP_BLEZ     6'b000110
`define OP_BGTZ     6'b000111
`define OP_ADDIU    6'b001001
`define OP_SLTI     6'b001010
`define OP_SLTIU    6'b001011
`define OP_ANDI     6'b001100
`define OP_ORI      6'b001101
`define OP_XORI     6'b001110
`define OP_LUI      6'b001111

// special funct field
`define FN_SLL      6'b000000
`define FN_SRL      6'b000010
`define FN_SRA      6'b000011
`define FN_SLLV     6'b000100
`define FN_SRLV     6'b000110
`define FN_SRAV     6'b000111
`define FN_JR       6'b001000
`define FN_JALR     6'b001001
`define FN_ADDU     6'b100001
`define FN_SUBU     6'b100011
`define FN_AND      6'b100100
`define FN_OR       6'b100101
`define FN_XOR      6'b100110
`define FN_NOR      6'b100111
`define FN_SLT      6'b101010
`define FN_SLTU     6'b101011

// regimm rt field where bit 0 set means the >= 0 test
`define RT_BLTZ     5'b00000
`define RT_BGEZ     5'b00001
`define RT_BLTZAL   5'b10000
`define RT_BGEZAL   5'b10001

`endif
